// ==== verilog/texture_cache_pkg.sv ====
// ---------------------------------------------------------------------
// texture cache sizes, vector types, bus structs, fetch states and
// coordinate split helpers
// ---------------------------------------------------------------------

package texture_cache_pkg;

    localparam int ADDR_X_WIDTH     = 8;
    localparam int ADDR_Y_WIDTH     = 8;
    localparam int BLK_X_SIZE       = 2;    // log2 block width
    localparam int BLK_Y_SIZE       = 2;    // log2 block height
    localparam int TAG_ADDR_WIDTH   = 4;
    localparam int PIXEL_WIDTH      = 24;
    localparam int USER_WIDTH       = 4;

    localparam int TAG_X_BITS       = TAG_ADDR_WIDTH / 2;
    localparam int TAG_Y_BITS       = TAG_ADDR_WIDTH - TAG_X_BITS;
    localparam int BLK_OFFSET_WIDTH = BLK_X_SIZE + BLK_Y_SIZE;
    localparam int TAG_VALUE_WIDTH  = ADDR_X_WIDTH + ADDR_Y_WIDTH - BLK_OFFSET_WIDTH
                                      - TAG_ADDR_WIDTH;
    localparam int TAG_NUM          = 1 << TAG_ADDR_WIDTH;
    localparam int MEM_ADDR_WIDTH   = TAG_ADDR_WIDTH + BLK_OFFSET_WIDTH;
    localparam int MEM_DEPTH        = 1 << MEM_ADDR_WIDTH;

    typedef logic [ADDR_X_WIDTH-1:0]     addr_x_t;
    typedef logic [ADDR_Y_WIDTH-1:0]     addr_y_t;
    typedef logic [PIXEL_WIDTH-1:0]      pixel_t;
    typedef logic [USER_WIDTH-1:0]       user_t;
    typedef logic [TAG_ADDR_WIDTH-1:0]   tag_index_t;
    typedef logic [TAG_VALUE_WIDTH-1:0]  tag_value_t;
    typedef logic [BLK_OFFSET_WIDTH-1:0] blk_offset_t;    // {y offset, x offset}
    typedef logic [MEM_ADDR_WIDTH-1:0]   mem_addr_t;      // {line, offset}

    typedef struct packed {
        user_t   user;
        addr_x_t addrx;
        addr_y_t addry;
        logic    strb;      // low: outside the image
    } tex_req_t;

    typedef struct packed {
        user_t  user;
        pixel_t data;
        logic   strb;
    } tex_resp_t;

    typedef struct packed {
        addr_x_t addrx;
        addr_y_t addry;
    } blk_addr_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_FILL
    } fetch_state_t;

    // -----------------------------------------------------------------
    // coordinate split
    // -----------------------------------------------------------------
    function automatic tag_index_t calc_index(addr_x_t x, addr_y_t y);
        return {y[BLK_Y_SIZE +: TAG_Y_BITS], x[BLK_X_SIZE +: TAG_X_BITS]};
    endfunction

    function automatic tag_value_t calc_tag(addr_x_t x, addr_y_t y);
        return {y[ADDR_Y_WIDTH-1:BLK_Y_SIZE+TAG_Y_BITS],
                x[ADDR_X_WIDTH-1:BLK_X_SIZE+TAG_X_BITS]};
    endfunction

    function automatic blk_offset_t calc_offset(addr_x_t x, addr_y_t y);
        return {y[BLK_Y_SIZE-1:0], x[BLK_X_SIZE-1:0]};
    endfunction

    function automatic blk_addr_t blk_align(addr_x_t x, addr_y_t y);
        blk_addr_t blk;
        blk.addrx = {x[ADDR_X_WIDTH-1:BLK_X_SIZE], {BLK_X_SIZE{1'b0}}};
        blk.addry = {y[ADDR_Y_WIDTH-1:BLK_Y_SIZE], {BLK_Y_SIZE{1'b0}}};
        return blk;
    endfunction

endpackage

// ==== verilog/texture_cache_tag.sv ====
// ---------------------------------------------------------------------
// direct-mapped tag array with valid bits, hit compare and clear sweep
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module texture_cache_tag (
    input  logic                           clk,
    input  logic                           rst_n,

    input  texture_cache_pkg::tag_index_t  lookup_index,
    input  texture_cache_pkg::tag_value_t  lookup_tag,
    output logic                           hit,

    input  logic                           fill_done,
    input  texture_cache_pkg::tag_index_t  fill_index,
    input  texture_cache_pkg::tag_value_t  fill_tag,

    input  logic                           clear_start,
    output logic                           clear_busy
);

    import texture_cache_pkg::*;

    tag_value_t         tag_mem [TAG_NUM];
    logic [TAG_NUM-1:0] valid_bits;
    tag_index_t         clear_cnt;

    // ------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------
    assign hit = valid_bits[lookup_index] && (tag_mem[lookup_index] == lookup_tag);

    // ------------------------------------------------------------------
    // update
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[fill_index] <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (clear_busy) begin
            valid_bits[clear_cnt] <= 1'b0;      // one line per cycle
        end else if (fill_done) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // clear sweep
    // ------------------------------------------------------------------
    // busy for TAG_NUM cycles, starting the cycle after clear_start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clear_busy <= 1'b0;
            clear_cnt  <= '0;
        end else if (clear_busy) begin
            clear_cnt <= clear_cnt + 1'b1;
            if (clear_cnt == tag_index_t'(TAG_NUM - 1)) begin
                clear_busy <= 1'b0;             // last line swept
            end
        end else if (clear_start) begin
            clear_busy <= 1'b1;
            clear_cnt  <= '0;
        end
    end

endmodule

// ==== verilog/texture_cache_fetch.sv ====
// ---------------------------------------------------------------------
// miss engine: block read request and fill of the pixel data array
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module texture_cache_fetch (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            miss_start,
    input  texture_cache_pkg::blk_addr_t    miss_blk,
    input  texture_cache_pkg::tag_index_t   miss_index,
    output logic                            busy,

    output logic                            fill_we,
    output texture_cache_pkg::tag_index_t   fill_index,
    output texture_cache_pkg::blk_offset_t  fill_offset,
    output texture_cache_pkg::pixel_t       fill_data,
    output logic                            fill_done,

    output texture_cache_pkg::blk_addr_t    m_ar,
    output logic                            m_arvalid,
    input  logic                            m_arready,
    input  texture_cache_pkg::pixel_t       m_rdata,
    input  logic                            m_rlast,
    input  logic                            m_rvalid,
    output logic                            m_rready
);

    import texture_cache_pkg::*;

    fetch_state_t state;
    blk_addr_t    blk_reg;
    tag_index_t   index_reg;
    blk_offset_t  beat_cnt;

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= FETCH_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (miss_start) begin
                        state <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (m_arready) begin
                        state    <= FETCH_FILL;
                        beat_cnt <= '0;
                    end
                end
                FETCH_FILL: begin
                    if (m_rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;    // beats arrive in raster order
                        if (m_rlast) begin
                            state <= FETCH_IDLE;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // block address and target line of the current miss
    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && miss_start) begin
            blk_reg   <= miss_blk;
            index_reg <= miss_index;
        end
    end

    assign busy      = (state != FETCH_IDLE);
    assign m_ar      = blk_reg;
    assign m_arvalid = (state == FETCH_REQ);
    assign m_rready  = (state == FETCH_FILL);

    assign fill_we     = m_rready && m_rvalid;
    assign fill_index  = index_reg;
    assign fill_offset = beat_cnt;
    assign fill_data   = m_rdata;
    assign fill_done   = fill_we && m_rlast;

endmodule

// ==== verilog/texture_cache_basic.sv ====
// ---------------------------------------------------------------------
// access control, pixel data array and response register
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module texture_cache_basic (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          clear_start,
    output logic                          clear_busy,

    input  texture_cache_pkg::pixel_t     param_blank_value,

    output logic                          status_idle,
    output logic                          status_hit,
    output logic                          status_miss,
    output logic                          status_blank,

    input  texture_cache_pkg::tex_req_t   s_ar,
    input  logic                          s_arvalid,
    output logic                          s_arready,
    output texture_cache_pkg::tex_resp_t  s_r,
    output logic                          s_rvalid,
    input  logic                          s_rready,

    output texture_cache_pkg::blk_addr_t  m_ar,
    output logic                          m_arvalid,
    input  logic                          m_arready,
    input  texture_cache_pkg::pixel_t     m_rdata,
    input  logic                          m_rlast,
    input  logic                          m_rvalid,
    output logic                          m_rready
);

    import texture_cache_pkg::*;

    tex_req_t    req_reg;
    logic        resp_valid;
    logic        miss_wait;
    pixel_t      rd_data;
    pixel_t      data_mem [MEM_DEPTH];

    tag_index_t  in_index;
    tag_value_t  in_tag;
    blk_offset_t in_offset;
    mem_addr_t   rd_addr;
    logic        hit;
    logic        accept;
    logic        is_hit;
    logic        is_miss;
    logic        is_blank;
    logic        rd_en;
    logic        reread;
    logic        clear_go;

    logic        fetch_busy;
    logic        fill_we;
    tag_index_t  fill_index;
    blk_offset_t fill_offset;
    pixel_t      fill_data;
    logic        fill_done;

    // ------------------------------------------------------------------
    // request decode
    // ------------------------------------------------------------------
    assign in_index  = calc_index(s_ar.addrx, s_ar.addry);
    assign in_tag    = calc_tag(s_ar.addrx, s_ar.addry);
    assign in_offset = calc_offset(s_ar.addrx, s_ar.addry);

    assign accept   = s_arvalid && s_arready;
    assign is_blank = !s_ar.strb;
    assign is_hit   = s_ar.strb && hit;
    assign is_miss  = s_ar.strb && !hit;

    assign reread   = miss_wait && !fetch_busy;     // fill finished, read the line again
    assign clear_go = clear_start && !resp_valid && !miss_wait && !clear_busy;

    assign s_arready = !miss_wait && !clear_busy && !clear_go && (!resp_valid || s_rready);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_reg <= s_ar;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            miss_wait  <= 1'b0;
        end else begin
            if (s_rready) begin
                resp_valid <= 1'b0;
            end
            if (accept && !is_miss) begin
                resp_valid <= 1'b1;                 // hit or blank
            end
            if (accept && is_miss) begin
                miss_wait <= 1'b1;
            end
            if (reread) begin
                miss_wait  <= 1'b0;
                resp_valid <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // pixel data array
    // ------------------------------------------------------------------
    assign rd_en   = (accept && is_hit) || reread;
    assign rd_addr = reread ? {calc_index(req_reg.addrx, req_reg.addry),
                               calc_offset(req_reg.addrx, req_reg.addry)}
                            : {in_index, in_offset};

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[{fill_index, fill_offset}] <= fill_data;
        end
    end

    // output register, held while the response waits
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= data_mem[rd_addr];
        end else if (accept && is_blank) begin
            rd_data <= param_blank_value;
        end
    end

    assign s_r      = '{user: req_reg.user, data: rd_data, strb: req_reg.strb};
    assign s_rvalid = resp_valid;

    assign status_idle  = !resp_valid && !miss_wait && !clear_busy;
    assign status_hit   = accept && is_hit;
    assign status_miss  = accept && is_miss;
    assign status_blank = accept && is_blank;

    // ------------------------------------------------------------------
    // tags and miss engine
    // ------------------------------------------------------------------
    texture_cache_tag i_texture_cache_tag (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_index   (in_index),
        .lookup_tag     (in_tag),
        .hit            (hit),
        .fill_done      (fill_done),
        .fill_index     (fill_index),
        .fill_tag       (calc_tag(m_ar.addrx, m_ar.addry)),   // latched miss block
        .clear_start    (clear_go),
        .clear_busy     (clear_busy)
    );

    texture_cache_fetch i_texture_cache_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .miss_start     (accept && is_miss),
        .miss_blk       (blk_align(s_ar.addrx, s_ar.addry)),
        .miss_index     (in_index),
        .busy           (fetch_busy),
        .fill_we        (fill_we),
        .fill_index     (fill_index),
        .fill_offset    (fill_offset),
        .fill_data      (fill_data),
        .fill_done      (fill_done),
        .m_ar           (m_ar),
        .m_arvalid      (m_arvalid),
        .m_arready      (m_arready),
        .m_rdata        (m_rdata),
        .m_rlast        (m_rlast),
        .m_rvalid       (m_rvalid),
        .m_rready       (m_rready)
    );

endmodule

// ==== verilog/texture_cache_unit.sv ====
// ---------------------------------------------------------------------
// texture cache top level around the basic cache
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module texture_cache_unit (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          clear_start,
    output logic                          clear_busy,

    input  texture_cache_pkg::pixel_t     param_blank_value,

    output logic                          status_idle,
    output logic                          status_hit,
    output logic                          status_miss,
    output logic                          status_blank,

    input  texture_cache_pkg::tex_req_t   s_ar,
    input  logic                          s_arvalid,
    output logic                          s_arready,
    output texture_cache_pkg::tex_resp_t  s_r,
    output logic                          s_rvalid,
    input  logic                          s_rready,

    output texture_cache_pkg::blk_addr_t  m_ar,
    output logic                          m_arvalid,
    input  logic                          m_arready,
    input  texture_cache_pkg::pixel_t     m_rdata,
    input  logic                          m_rlast,
    input  logic                          m_rvalid,
    output logic                          m_rready
);

    texture_cache_basic i_texture_cache_basic (
        .clk                (clk),
        .rst_n              (rst_n),
        .clear_start        (clear_start),
        .clear_busy         (clear_busy),
        .param_blank_value  (param_blank_value),
        .status_idle        (status_idle),
        .status_hit         (status_hit),
        .status_miss        (status_miss),
        .status_blank       (status_blank),
        .s_ar               (s_ar),
        .s_arvalid          (s_arvalid),
        .s_arready          (s_arready),
        .s_r                (s_r),
        .s_rvalid           (s_rvalid),
        .s_rready           (s_rready),
        .m_ar               (m_ar),
        .m_arvalid          (m_arvalid),
        .m_arready          (m_arready),
        .m_rdata            (m_rdata),
        .m_rlast            (m_rlast),
        .m_rvalid           (m_rvalid),
        .m_rready           (m_rready)
    );

endmodule

// ==== tb/tb_texture_memory.sv ====
// ----------------------------------------------------------------------
// behavioral texture memory, block reads with random handshake gaps
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_texture_memory (
    input  logic                          clk,
    input  logic                          rst_n,
    input  texture_cache_pkg::blk_addr_t  m_ar,
    input  logic                          m_arvalid,
    output logic                          m_arready,
    output texture_cache_pkg::pixel_t     m_rdata,
    output logic                          m_rlast,
    output logic                          m_rvalid,
    input  logic                          m_rready
);

    import texture_cache_pkg::*;

    int        seed = 32'hf454;
    int        gap;
    int        beat;
    blk_addr_t blk;

    // texel content: x in the low byte, y above it, x xor y on top
    function automatic pixel_t pixel_at(addr_x_t x, addr_y_t y);
        return {x ^ y, y, x};
    endfunction

    initial begin
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rlast   = 1'b0;
        m_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            m_arready = rst_n && (({$random(seed)} % 3) == 0);
            @(negedge clk);
            if (m_arvalid && m_arready) begin
                blk = m_ar;
                @(posedge clk);             // address handshake edge
                #1;
                m_arready = 1'b0;
                for (beat = 0; beat < 16; beat++) begin
                    gap = (({$random(seed)} % 4) == 0) ? 2 : 0;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    // raster order, beat index is {y offset, x offset}
                    m_rdata  = pixel_at(blk.addrx + addr_x_t'(beat % 4),
                                        blk.addry + addr_y_t'(beat / 4));
                    m_rlast  = (beat == 15);
                    m_rvalid = 1'b1;
                    do @(negedge clk); while (!m_rready);
                    @(posedge clk);
                    #1;
                    m_rvalid = 1'b0;
                    m_rlast  = 1'b0;
                end
            end
        end
    end

endmodule

// ==== tb/tb_texture_cache.sv ====
// ----------------------------------------------------------------------
// texture cache testbench with stimulus, tag model, scoreboard and assertions
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_texture_cache;

    import texture_cache_pkg::*;

    localparam int NUM_RANDOM      = 240;
    localparam int NUM_REQ         = NUM_RANDOM + 2;
    localparam int RESET_CYCLES    = 8;
    localparam int CLEAR_CYCLES    = 16 + 8;
    localparam int WATCHDOG_CYCLES = NUM_REQ * 40 + RESET_CYCLES + CLEAR_CYCLES;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       clear_start;
    logic       clear_busy;
    pixel_t     param_blank_value;
    logic       status_idle;
    logic       status_hit;
    logic       status_miss;
    logic       status_blank;
    tex_req_t   s_ar;
    logic       s_arvalid;
    logic       s_arready;
    tex_resp_t  s_r;
    logic       s_rvalid;
    logic       s_rready;
    blk_addr_t  m_ar;
    logic       m_arvalid;
    logic       m_arready;
    pixel_t     m_rdata;
    logic       m_rlast;
    logic       m_rvalid;
    logic       m_rready;

    int          seed       = 32'hf454;
    int          ready_seed = 32'hf454;
    tex_resp_t   resp_q[$];         // expected responses in order
    blk_addr_t   read_q[$];         // expected block reads
    logic [7:0]  model_tag [16];
    logic [15:0] model_valid;
    logic        filling;           // block read accepted, last beat not yet taken
    logic [3:0]  idx;
    logic [7:0]  tg;
    logic        present;
    tex_resp_t   exp_resp;
    tex_resp_t   want;
    blk_addr_t   exp_blk;
    blk_addr_t   want_blk;
    addr_x_t     last_x;
    addr_y_t     last_y;
    int          clear_cycles;
    int          clears_seen;
    int          data_errors;
    int          status_errors;
    int          memory_errors;
    int          protocol_errors;

    always #5 clk = ~clk;

    texture_cache_unit dut (.*);

    tb_texture_memory mem (.*);

    task automatic note_protocol_error(input string what);
        protocol_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // ------------------------------------------------------------------
    // protocol assertions
    // ------------------------------------------------------------------
    hold_check: assert property (@(posedge clk) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
        else note_protocol_error("response dropped or changed under back-pressure");

    clear_ready_check: assert property (@(posedge clk) disable iff (!rst_n)
        clear_busy |-> !s_arready)
        else note_protocol_error("request accepted during clear");

    clear_start_check: assert property (@(posedge clk) disable iff (!rst_n)
        clear_start && status_idle |=> clear_busy)
        else note_protocol_error("clear did not start");

    hit_latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        status_hit || status_blank |=> s_rvalid)
        else note_protocol_error("hit or blank response not valid next cycle");

    // ------------------------------------------------------------------
    // model and scoreboard sampled mid-cycle
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (s_arvalid && s_arready) begin
                exp_resp.user = s_ar.user;
                if (s_ar.strb) begin
                    idx     = {s_ar.addry[3:2], s_ar.addrx[3:2]};
                    tg      = {s_ar.addry[7:4], s_ar.addrx[7:4]};
                    present = model_valid[idx] && (model_tag[idx] == tg);
                    exp_resp.data = {s_ar.addrx ^ s_ar.addry, s_ar.addry, s_ar.addrx};
                    exp_resp.strb = 1'b1;
                    assert (status_hit == present && status_miss == !present && !status_blank)
                    else begin
                        status_errors++;
                        $display("error at %0t: status hit %b miss %b, block present %b",
                                 $time, status_hit, status_miss, present);
                    end
                    if (!present) begin
                        model_valid[idx] = 1'b1;
                        model_tag[idx]   = tg;
                        exp_blk.addrx    = {s_ar.addrx[7:2], 2'b00};
                        exp_blk.addry    = {s_ar.addry[7:2], 2'b00};
                        read_q.push_back(exp_blk);
                    end
                end else begin
                    exp_resp.data = param_blank_value;
                    exp_resp.strb = 1'b0;
                    assert (status_blank && !status_hit && !status_miss) else begin
                        status_errors++;
                        $display("error at %0t: blank request without status_blank", $time);
                    end
                end
                resp_q.push_back(exp_resp);
            end else begin
                assert (!status_hit && !status_miss && !status_blank) else begin
                    status_errors++;
                    $display("error at %0t: status pulse without a request", $time);
                end
            end

            if (s_rvalid && s_rready) begin
                if (resp_q.size() == 0) begin
                    data_errors++;
                    $display("error at %0t: response without a request", $time);
                end else begin
                    want = resp_q.pop_front();
                    assert (s_r == want) else begin
                        data_errors++;
                        $display("error at %0t: response %h/%h/%b, expected %h/%h/%b",
                                 $time, s_r.user, s_r.data, s_r.strb,
                                 want.user, want.data, want.strb);
                    end
                end
            end

            // m_rready spans the fill from the address handshake to the last beat
            assert (m_rready == filling) else begin
                memory_errors++;
                $display("error at %0t: m_rready %b while a fill in progress is %b",
                         $time, m_rready, filling);
            end

            if (m_arvalid && m_arready) begin
                filling = 1'b1;
                if (read_q.size() == 0) begin
                    memory_errors++;
                    $display("error at %0t: memory read without a miss", $time);
                end else begin
                    want_blk = read_q.pop_front();
                    assert (m_ar == want_blk) else begin
                        memory_errors++;
                        $display("error at %0t: block read %h,%h, expected %h,%h", $time,
                                 m_ar.addrx, m_ar.addry, want_blk.addrx, want_blk.addry);
                    end
                end
            end

            if (m_rvalid && m_rready && m_rlast) begin
                filling = 1'b0;
            end

            if (clear_busy) begin
                clear_cycles++;
                model_valid = '0;           // sweep empties the whole cache
            end else if (clear_cycles != 0) begin
                assert (clear_cycles == 16) else begin
                    protocol_errors++;
                    $display("error at %0t: clear_busy lasted %0d cycles", $time, clear_cycles);
                end
                clears_seen++;
                clear_cycles = 0;
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    // called at rising edge plus 1 ns and returns there after the transfer
    task automatic send_request(input addr_x_t x, input addr_y_t y, input logic strb,
                                input user_t user);
        s_ar.addrx = x;
        s_ar.addry = y;
        s_ar.strb  = strb;
        s_ar.user  = user;
        s_arvalid  = 1'b1;
        do @(negedge clk); while (!s_arready);
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
    endtask

    task automatic run_random(input int count);
        addr_x_t x;
        addr_y_t y;
        logic    strb;
        user_t   user;
        int      gap;
        repeat (count) begin
            x    = addr_x_t'(40 + {$random(seed)} % 24);
            y    = addr_y_t'(72 + {$random(seed)} % 24);
            strb = ({$random(seed)} % 8) != 0;
            user = user_t'($random(seed));
            gap  = (({$random(seed)} % 4) == 0) ? 1 : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_request(x, y, strb, user);
            if (strb) begin
                last_x = x;
                last_y = y;
            end
        end
    endtask

    task automatic drain;
        while (resp_q.size() != 0 || !status_idle) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic clear_cache;
        clear_start = 1'b1;
        @(posedge clk);
        #1;
        clear_start = 1'b0;
        while (clear_busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        s_rready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            s_rready = rst_n && (({$random(ready_seed)} % 4) != 0);
        end
    end

    initial begin
        rst_n             = 1'b0;
        clear_start       = 1'b0;
        param_blank_value = 24'h5ac30f;
        s_ar              = '0;
        s_arvalid         = 1'b0;
        model_valid       = '0;
        filling           = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!s_rvalid && !m_arvalid && !m_rready && !clear_busy && status_idle) else begin
            status_errors++;
            $display("error at %0t: outputs not in their reset state", $time);
        end
        @(posedge clk);
        #1;
        run_random(NUM_RANDOM / 2);
        drain();
        clear_cache();
        send_request(last_x, last_y, 1'b1, 4'h5);     // swept block must miss again
        send_request(last_x, last_y, 1'b1, 4'ha);
        run_random(NUM_RANDOM / 2);
        drain();
        repeat (4) @(posedge clk);
        if (resp_q.size() != 0 || read_q.size() != 0) begin
            $display("responses or memory reads were still outstanding at the end");
            memory_errors++;
        end
        if (clears_seen == 0) begin
            $display("the clear sequence never ran");
            protocol_errors++;
        end
        $display("errors: data %0d, status %0d, memory %0d, protocol %0d",
                 data_errors, status_errors, memory_errors, protocol_errors);
        if (data_errors + status_errors + memory_errors + protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/texture_cache_pkg.sv
verilog/texture_cache_tag.sv
verilog/texture_cache_fetch.sv
verilog/texture_cache_basic.sv
verilog/texture_cache_unit.sv
tb/tb_texture_memory.sv
tb/tb_texture_cache.sv

// ==== Makefile ====
TOP := tb_texture_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module texture_cache_unit \
		verilog/texture_cache_pkg.sv verilog/texture_cache_tag.sv \
		verilog/texture_cache_fetch.sv verilog/texture_cache_basic.sv \
		verilog/texture_cache_unit.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
